//--- verilog/l15_pkg.sv
package l15_pkg;

	// transducer port widths
	localparam int L15_ADDR_W = 32;
	localparam int L15_BEAT_W = 64; // data_0 and data_1 only

	// request types, only rq_load is issued by the fetch
	typedef enum logic [4:0]
	{
		rq_load     = 5'b00000,
		rq_store    = 5'b00001,
		rq_cas1     = 5'b00010,
		rq_cas2     = 5'b00011,
		rq_swap     = 5'b00110,
		rq_int      = 5'b01001,
		rq_imiss    = 5'b10000
	} l15_rqtype_e;

	// return types seen on the response side
	typedef enum logic [3:0]
	{
		ret_load      = 4'b0000,
		ret_ifill     = 4'b0001,
		ret_strload   = 4'b0010,
		ret_evict     = 4'b0011, // shared by inv and atomic ack
		ret_st_ack    = 4'b0100,
		ret_test      = 4'b0101,
		ret_strst_ack = 4'b0110,
		ret_int       = 4'b0111, // wake-up message
		ret_fp        = 4'b1000,
		ret_fwd_rq    = 4'b1010,
		ret_fwd_rpy   = 4'b1011,
		ret_err       = 4'b1100,
		ret_rsvd      = 4'b1111
	} l15_rettype_e;

	typedef enum logic [2:0]
	{
		size_0b = 3'd0, size_1b = 3'd1, size_2b = 3'd2, size_4b = 3'd3,
		size_8b = 3'd4, size_16b = 3'd5, size_32b = 3'd6, size_64b = 3'd7
	} l15_size_e;

endpackage

//--- verilog/fetch_pkg.sv
package fetch_pkg;

	// boot address after reset and for the reset_vec select
	localparam logic [31:0] RESET_PC = 32'h4000_0000;

	// add x0, x0, x0 shown to decode while nothing is fetched
	localparam logic [31:0] NOP_INSTR = 32'h0000_0033;

	localparam logic [31:0] PC_STEP = 32'd4; // one instruction

	// next-pc source for the closing edge of a delivery
	typedef enum logic [1:0]
	{
		pcsel_seq       = 2'd0,
		pcsel_reset_vec = 2'd1,
		pcsel_target    = 2'd2,
		pcsel_hold      = 2'd3
	} pcsel_e;

	// fetch sequencing
	typedef enum logic [1:0]
	{
		st_req       = 2'd0, // request out until the header ack
		st_wait_resp = 2'd1, // waiting for the fill
		st_deliver   = 2'd2  // word shown to decode for one cycle
	} fetch_state_e;

endpackage

//--- verilog/fetch_if.sv
`timescale 1ns/1ps

// link between pc sequencing and the L1.5 fetch port
interface fetch_if;

	logic [31:0] pc;      // address of the instruction being fetched
	logic        awake;   // wake-up message has arrived
	logic        deliver; // one-cycle strobe, word valid on instr
	logic [31:0] instr;   // fetched word or no-op

	modport pc_side
	(
		output pc,
		input  awake,
		input  deliver
	);

	modport port_side
	(
		input  pc,
		output awake,
		output deliver,
		output instr
	);

endinterface

//--- verilog/pc_unit.sv
`timescale 1ns/1ps

module pc_unit
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              stall,
	input  fetch_pkg::pcsel_e pcsel,
	input  logic [31:0]       target,
	output logic [31:0]       pc2,
	fetch_if.pc_side          fif
);
	import fetch_pkg::*;

	logic [31:0] pc_q;
	logic [31:0] npc;
	logic        pc_load;

	// next pc choice, only consumed at the end of a delivery
	always_comb
	begin
		case (pcsel)
			pcsel_seq:       npc = pc_q + PC_STEP;
			pcsel_reset_vec: npc = RESET_PC;
			pcsel_target:    npc = target;
			pcsel_hold:      npc = pc_q;
			default:         npc = pc_q + PC_STEP;
		endcase
	end

	// stall keeps the same address so it is fetched again
	assign pc_load = fif.awake && fif.deliver && !stall;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc_q <= RESET_PC;
		end
		else if (pc_load)
		begin
			pc_q <= npc;
		end
	end

	// The pc does not move between the request and the end of delivery,
	// so following it outside delivery leaves pc2 on the address that
	// was current on the edge entering deliver. It is frozen while the
	// word is shown.
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc2 <= RESET_PC;
		end
		else if (!fif.deliver)
		begin
			pc2 <= pc_q;
		end
	end

	assign fif.pc = pc_q;

endmodule

//--- verilog/l15_fetch_port.sv
`timescale 1ns/1ps

module l15_fetch_port
(
	input  logic                              clk,
	input  logic                              nrst,
	fetch_if.port_side                        fif,
	output fetch_pkg::fetch_state_e           state,

	// request side
	output l15_pkg::l15_rqtype_e              transducer_l15_rqtype,
	output l15_pkg::l15_size_e                transducer_l15_size,
	output logic [l15_pkg::L15_ADDR_W-1:0]    transducer_l15_address,
	output logic [31:0]                       transducer_l15_data,
	output logic                              transducer_l15_val,
	input  logic                              l15_transducer_ack,        // not needed for loads
	input  logic                              l15_transducer_header_ack,

	// response side
	input  logic                              l15_transducer_val,
	input  logic [l15_pkg::L15_BEAT_W-1:0]    l15_transducer_data_0,
	input  logic [l15_pkg::L15_BEAT_W-1:0]    l15_transducer_data_1,
	input  logic [31:0]                       l15_transducer_data_2,     // unused by a 4-byte fetch
	input  logic [31:0]                       l15_transducer_data_3,
	input  l15_pkg::l15_rettype_e             l15_transducer_returntype,
	output logic                              transducer_l15_req_ack
);
	import l15_pkg::*;
	import fetch_pkg::*;

	fetch_state_e state_q;
	fetch_state_e state_d;

	logic        awake_q;
	logic        wake_msg;
	logic        is_data_ret; // load or ifill
	logic        is_foreign;
	logic        req_fire;
	logic        fill;
	logic [31:0] sel_word;
	logic [31:0] word_q;

	// return classification
	assign is_data_ret = (l15_transducer_returntype == ret_load) ||
		(l15_transducer_returntype == ret_ifill);

	// anything besides load, ifill and store ack is dropped
	assign is_foreign = l15_transducer_val && !is_data_ret &&
		(l15_transducer_returntype != ret_st_ack);

	assign wake_msg = l15_transducer_val && (l15_transducer_returntype == ret_int);

	// wake-up latch, set once by the first interrupt return
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			awake_q <= 1'b0;
		end
		else if (!awake_q && wake_msg)
		begin
			awake_q <= 1'b1;
		end
	end

	// handshake events
	assign req_fire = transducer_l15_val && l15_transducer_header_ack;
	assign fill     = l15_transducer_val && is_data_ret && (state_q == st_wait_resp);

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			st_req:
			begin
				if (req_fire)
				begin
					state_d = st_wait_resp;
				end
			end
			st_wait_resp:
			begin
				if (fill)
				begin
					state_d = st_deliver;
				end
			end
			st_deliver:
			begin
				state_d = st_req; // always a single cycle
			end
			default:
			begin
				state_d = st_req;
			end
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			state_q <= st_req;
		end
		else
		begin
			state_q <= state_d;
		end
	end

	// word select from the two 64-bit beats, big-endian within a beat
	always_comb
	begin
		case (fif.pc[3:2])
			2'b00:   sel_word = l15_transducer_data_0[63:32];
			2'b01:   sel_word = l15_transducer_data_0[31:0];
			2'b10:   sel_word = l15_transducer_data_1[63:32];
			default: sel_word = l15_transducer_data_1[31:0];
		endcase
	end

	// fetched word, valid from the fill edge through delivery
	always_ff @(posedge clk)
	begin
		if (fill)
		begin
			word_q <= sel_word;
		end
	end

	// request drive, one 4-byte load at the current pc
	assign transducer_l15_val     = awake_q && (state_q == st_req);
	assign transducer_l15_rqtype  = rq_load;
	assign transducer_l15_size    = size_4b;
	assign transducer_l15_address = fif.pc;
	assign transducer_l15_data    = '0;

	// foreign returns acked at once, fills acked as they are taken
	assign transducer_l15_req_ack = awake_q && (is_foreign || fill);

	assign fif.awake   = awake_q;
	assign fif.deliver = (state_q == st_deliver);
	assign fif.instr   = (state_q == st_deliver) ? word_q : NOP_INSTR;

	assign state = state_q;

endmodule

//--- verilog/frontend_stage.sv
`timescale 1ns/1ps

module frontend_stage
(
	input  logic                            clk,
	input  logic                            nrst,
	input  logic                            stall,
	input  fetch_pkg::pcsel_e               pcsel,
	input  logic [31:0]                     target,

	// to decode
	output logic [31:0]                     pc2,
	output logic [31:0]                     instr2,
	output fetch_pkg::fetch_state_e         state,

	// L1.5 request
	output l15_pkg::l15_rqtype_e            transducer_l15_rqtype,
	output l15_pkg::l15_size_e              transducer_l15_size,
	output logic [l15_pkg::L15_ADDR_W-1:0]  transducer_l15_address,
	output logic [31:0]                     transducer_l15_data,
	output logic                            transducer_l15_val,
	input  logic                            l15_transducer_ack,
	input  logic                            l15_transducer_header_ack,

	// L1.5 response
	input  logic                            l15_transducer_val,
	input  logic [l15_pkg::L15_BEAT_W-1:0]  l15_transducer_data_0,
	input  logic [l15_pkg::L15_BEAT_W-1:0]  l15_transducer_data_1,
	input  logic [31:0]                     l15_transducer_data_2,
	input  logic [31:0]                     l15_transducer_data_3,
	input  l15_pkg::l15_rettype_e           l15_transducer_returntype,
	output logic                            transducer_l15_req_ack
);

	fetch_if fif ();

	pc_unit u_pc
	(
		.clk    (clk),
		.nrst   (nrst),
		.stall  (stall),
		.pcsel  (pcsel),
		.target (target),
		.pc2    (pc2),
		.fif    (fif.pc_side)
	);

	l15_fetch_port u_port
	(
		.clk                       (clk),
		.nrst                      (nrst),
		.fif                       (fif.port_side),
		.state                     (state),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.transducer_l15_data       (transducer_l15_data),
		.transducer_l15_val        (transducer_l15_val),
		.l15_transducer_ack        (l15_transducer_ack),
		.l15_transducer_header_ack (l15_transducer_header_ack),
		.l15_transducer_val        (l15_transducer_val),
		.l15_transducer_data_0     (l15_transducer_data_0),
		.l15_transducer_data_1     (l15_transducer_data_1),
		.l15_transducer_data_2     (l15_transducer_data_2),
		.l15_transducer_data_3     (l15_transducer_data_3),
		.l15_transducer_returntype (l15_transducer_returntype),
		.transducer_l15_req_ack    (transducer_l15_req_ack)
	);

	assign instr2 = fif.instr; // no-op outside delivery

endmodule

//--- tb/l15_model.sv
`timescale 1ns/1ps

// L1.5 stand-in: one wake-up after reset, then answers each fetch after random delays
module l15_model
(
	input  logic                  clk,
	input  logic                  nrst,
	input  logic                  transducer_l15_val,
	input  logic [31:0]           transducer_l15_address,
	output logic                  l15_transducer_ack,
	output logic                  l15_transducer_header_ack,
	output logic                  l15_transducer_val,
	output logic [63:0]           l15_transducer_data_0,
	output logic [63:0]           l15_transducer_data_1,
	output logic [31:0]           l15_transducer_data_2,
	output logic [31:0]           l15_transducer_data_3,
	output l15_pkg::l15_rettype_e l15_transducer_returntype
);
	import l15_pkg::*;

	logic [31:0] seed = 32'h4858_8910;
	logic [31:0] base; // 16-byte line of the current fetch
	int          d;
	int          k;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// word memory, each word holds its own address scrambled
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return addr ^ 32'hA5A5_0000;
	endfunction

	initial
	begin
		l15_transducer_ack        = 1'b0; // loads never need it
		l15_transducer_header_ack = 1'b0;
		l15_transducer_val        = 1'b0;
		l15_transducer_data_0     = '0;
		l15_transducer_data_1     = '0;
		l15_transducer_data_2     = '0;
		l15_transducer_data_3     = '0;
		l15_transducer_returntype = ret_load;
		@(negedge nrst);
		@(posedge nrst);
		repeat (3) @(posedge clk);
		l15_transducer_val        <= 1'b1; // interrupt return wakes the core
		l15_transducer_returntype <= ret_int;
		@(posedge clk);
		l15_transducer_val        <= 1'b0;
		forever
		begin
			@(posedge clk);
			if (transducer_l15_val)
			begin
				seed = lcg_next(seed);
				repeat ((seed >> 16) % 6) @(posedge clk); // request held, no header ack
				l15_transducer_header_ack <= 1'b1;
				@(posedge clk);
				l15_transducer_header_ack <= 1'b0;
				base = {transducer_l15_address[31:4], 4'h0};
				seed = lcg_next(seed);
				d    = (seed >> 16) % 6;
				for (k = 0; k < d; k++)
				begin
					seed = lcg_next(seed);
					l15_transducer_val        <= seed[24]; // foreign return now and then
					l15_transducer_returntype <= seed[26] ? ret_err :
						(seed[27] ? ret_st_ack : ret_evict);
					@(posedge clk);
				end
				l15_transducer_val        <= 1'b1;
				l15_transducer_returntype <= seed[28] ? ret_ifill : ret_load;
				l15_transducer_data_0     <= {mem_word(base), mem_word(base + 32'd4)};
				l15_transducer_data_1     <= {mem_word(base + 32'd8), mem_word(base + 32'd12)};
				@(posedge clk);
				l15_transducer_val        <= 1'b0;
			end
		end
	end

endmodule

//--- tb/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;
	import l15_pkg::*;
	import fetch_pkg::*;

	localparam int N_STEPS    = 12;
	localparam int WAIT_LIMIT = 40; // cycles allowed for any single wait

	logic         clk;
	logic         nrst;
	logic         stall;
	pcsel_e       pcsel;
	logic [31:0]  target;
	logic [31:0]  pc2;
	logic [31:0]  instr2;
	fetch_state_e state;
	l15_rqtype_e  transducer_l15_rqtype;
	l15_size_e    transducer_l15_size;
	logic [31:0]  transducer_l15_address;
	logic [31:0]  transducer_l15_data;
	logic         transducer_l15_val;
	logic         transducer_l15_req_ack;
	logic         l15_transducer_ack;
	logic         l15_transducer_header_ack;
	logic         l15_transducer_val;
	logic [63:0]  l15_transducer_data_0;
	logic [63:0]  l15_transducer_data_1;
	logic [31:0]  l15_transducer_data_2;
	logic [31:0]  l15_transducer_data_3;
	l15_rettype_e l15_transducer_returntype;

	// one row per delivery with the address of the request after it
	pcsel_e      tbl_pcsel [N_STEPS];
	logic        tbl_stall [N_STEPS];
	logic [31:0] tbl_target [N_STEPS];
	logic [31:0] tbl_next [N_STEPS];

	int          errors = 0;
	int          deliveries = 0;
	int          pending = 0; // accepted requests not yet delivered
	bit          timed_out = 1'b0;
	bit          armed = 1'b0;
	bit          awake_seen = 1'b0;
	bit          foreign_prev = 1'b0;
	bit          hold_prev = 1'b0;
	logic [31:0] hold_addr;
	logic [31:0] exp_pc; // own copy of the pc
	int          i;

	frontend_stage u_dut (.*);
	l15_model u_l15 (.*);

	always #50 clk = ~clk;

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr ^ 32'hA5A5_0000;
	endfunction

	function automatic bit is_fill(input l15_rettype_e rt);
		return (rt == ret_load) || (rt == ret_ifill);
	endfunction

	// event code 0 is the wake-up, 1 a request and 2 a fill while waiting
	function automatic bit seen(input int what);
		case (what)
			0:       seen = l15_transducer_val && (l15_transducer_returntype == ret_int);
			1:       seen = transducer_l15_val;
			default: seen = (state == st_wait_resp) && l15_transducer_val &&
				is_fill(l15_transducer_returntype);
		endcase
	endfunction

	task automatic report_fail(input string msg);
		errors++;
		$display("Fail at %0t ns: %s", $time, msg);
	endtask

	task automatic put_step(input int k, input pcsel_e sel, input logic stl,
		input logic [31:0] tgt, input logic [31:0] nxt);
		tbl_pcsel[k]  = sel;
		tbl_stall[k]  = stl;
		tbl_target[k] = tgt;
		tbl_next[k]   = nxt;
	endtask

	task automatic wait_for(input int what, input string name);
		int k;
		k = 0;
		@(posedge clk);
		while (!seen(what) && k < WAIT_LIMIT)
		begin
			@(posedge clk);
			k++;
		end
		if (!seen(what))
		begin
			$display("timeout: no %s within %0d clock cycles", name, WAIT_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	initial
	begin
		clk    = 1'b0;
		nrst   = 1'b1;
		stall  = 1'b0;
		pcsel  = pcsel_seq;
		target = '0;
		put_step(0,  pcsel_seq,       1'b0, 32'h0,         32'h4000_0004);
		put_step(1,  pcsel_seq,       1'b0, 32'h0,         32'h4000_0008);
		put_step(2,  pcsel_seq,       1'b0, 32'h0,         32'h4000_000C);
		put_step(3,  pcsel_target,    1'b0, 32'h4000_0104, 32'h4000_0104);
		put_step(4,  pcsel_seq,       1'b1, 32'h0,         32'h4000_0104); // refetch
		put_step(5,  pcsel_hold,      1'b0, 32'h0,         32'h4000_0104);
		put_step(6,  pcsel_seq,       1'b0, 32'h0,         32'h4000_0108);
		put_step(7,  pcsel_target,    1'b1, 32'h4000_0200, 32'h4000_0108); // stall beats target
		put_step(8,  pcsel_target,    1'b0, 32'h4000_0238, 32'h4000_0238);
		put_step(9,  pcsel_seq,       1'b0, 32'h0,         32'h4000_023C);
		put_step(10, pcsel_reset_vec, 1'b0, 32'h0,         32'h4000_0000);
		put_step(11, pcsel_seq,       1'b0, 32'h0,         32'h4000_0004);

		@(posedge clk);
		nrst <= 1'b0;
		repeat (5) @(posedge clk);
		nrst  <= 1'b1;
		armed = 1'b1;
		wait_for(0, "wake-up message");
		exp_pc = RESET_PC;
		for (i = 0; i <= N_STEPS && !timed_out; i++)
		begin
			wait_for(1, "fetch request");
			if (!timed_out && transducer_l15_address !== exp_pc)
				report_fail($sformatf("request address %h, expected %h",
					transducer_l15_address, exp_pc));
			if (!timed_out && (transducer_l15_rqtype !== rq_load ||
				transducer_l15_size !== size_4b || transducer_l15_data !== 32'h0))
				report_fail("request is not a 4-byte load with zero data");
			if (i < N_STEPS && !timed_out)
				wait_for(2, "fill return");
			if (i < N_STEPS && !timed_out)
			begin
				stall  <= tbl_stall[i]; // in place for the delivery cycle
				pcsel  <= tbl_pcsel[i];
				target <= tbl_target[i];
				@(posedge clk);
				if (state !== st_deliver)
					report_fail("no delivery cycle after the fill");
				if (pc2 !== exp_pc)
					report_fail($sformatf("pc2 %h, expected %h", pc2, exp_pc));
				if (instr2 !== fill_word(exp_pc))
					report_fail($sformatf("instr2 %h, expected %h",
						instr2, fill_word(exp_pc)));
				exp_pc = tbl_next[i];
			end
		end
		if (!timed_out && deliveries != N_STEPS)
			report_fail($sformatf("%0d deliveries, expected %0d", deliveries, N_STEPS));
		$display("deliveries %0d of %0d, errors %0d, timeouts %0d",
			deliveries, N_STEPS, errors, timed_out);
		if (errors == 0 && !timed_out)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// per-cycle port checks on the rising edge
	always @(posedge clk)
	begin
		if (armed && nrst)
		begin
			if (!awake_seen && (transducer_l15_val !== 1'b0 || pc2 !== RESET_PC ||
				state !== st_req))
				report_fail("fetch active before the wake-up message");
			if (state !== st_deliver && instr2 !== NOP_INSTR)
				report_fail($sformatf("instr2 %h outside delivery", instr2));
			if (foreign_prev && state !== st_wait_resp)
				report_fail("foreign return moved the state out of wait_resp");
			foreign_prev = 1'b0;
			if (awake_seen && l15_transducer_val && !is_fill(l15_transducer_returntype))
			begin
				foreign_prev = 1'b1;
				if (transducer_l15_req_ack !== (l15_transducer_returntype != ret_st_ack))
					report_fail($sformatf("req_ack %b for return type %0d",
						transducer_l15_req_ack, l15_transducer_returntype));
				if (state !== st_wait_resp)
					report_fail("foreign return seen outside wait_resp");
			end
			if (seen(2) && transducer_l15_req_ack !== 1'b1)
				report_fail("fill return not acknowledged");
			if (hold_prev && (transducer_l15_val !== 1'b1 ||
				transducer_l15_address !== hold_addr))
				report_fail("request dropped or changed before header ack");
			hold_prev = transducer_l15_val && !l15_transducer_header_ack;
			hold_addr = transducer_l15_address;
			if (transducer_l15_val && l15_transducer_header_ack)
			begin
				if (pending != 0)
					report_fail("second request accepted before delivery");
				pending = 1;
			end
			if (state === st_deliver)
			begin
				if (pending != 1)
					report_fail("delivery without an accepted request");
				pending = 0;
				deliveries++;
			end
			if (seen(0))
				awake_seen = 1'b1;
		end
	end

endmodule

//--- all.f
verilog/l15_pkg.sv
verilog/fetch_pkg.sv
verilog/fetch_if.sv
verilog/pc_unit.sv
verilog/l15_fetch_port.sv
verilog/frontend_stage.sv
tb/l15_model.sv
tb/tb_frontend.sv
